// File: hw/obj_pkg.sv
// ======================================================================
// Shared sizes, bus bundles and state types for the object block.
// Every object module imports this package, and the top level
// uses its types on its ports.
// ======================================================================

package obj_pkg;

    // Sizes
    localparam int OBJ_COUNT = 32;
    localparam int OBJ_H     = 16;
    localparam int LINE_W    = 256;
    localparam int ROM_AW    = 14;
    localparam int TBL_AW    = 7;

    typedef struct packed {
        logic       vflip;
        logic       hflip;
        logic [1:0] unused;
        logic [3:0] pal;
    } obj_attr_t;

    // Byte 3 down to byte 0
    typedef struct packed {
        logic [7:0] x;
        obj_attr_t  attr;
        logic [7:0] code;
        logic [7:0] y;
    } obj_entry_t;

    // Row already carries the vertical flip
    typedef struct packed {
        logic [7:0] code;
        logic [3:0] row;
        logic [7:0] x;
        logic [3:0] pal;
        logic       hflip;
    } draw_req_t;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [TBL_AW-1:0] adr;
        logic [7:0]        dat;
    } wb_req_t;

    typedef struct packed {
        logic       ack;
        logic [7:0] dat;
    } wb_rsp_t;

    typedef enum logic [1:0] {SCAN_IDLE, SCAN_READ, SCAN_TEST, SCAN_WAIT} scan_state_e;

    typedef enum logic [1:0] {DRAW_IDLE, DRAW_FETCH, DRAW_PAINT} draw_state_e;

endpackage

// File: hw/obj_ram.sv
// ======================================================================
// Object table of 32 four-byte entries. The CPU reaches it byte by
// byte over a Wishbone classic slave port. The scanner reads a whole
// entry at once on a second, independent port.
// ======================================================================

`timescale 1ns/1ps

module obj_ram (
    input  logic                clk,
    input  logic                rst,
    input  obj_pkg::wb_req_t    wb_req,
    output obj_pkg::wb_rsp_t    wb_rsp,
    input  logic [4:0]          scan_idx,
    output obj_pkg::obj_entry_t scan_entry
);
    import obj_pkg::*;

    logic [3:0][7:0] mem [OBJ_COUNT];

    logic       active;
    logic       ack_q;
    logic [7:0] rd_q;
    logic [4:0] cpu_idx;
    logic [1:0] cpu_byte;

    assign active   = wb_req.cyc & wb_req.stb;
    assign cpu_idx  = wb_req.adr[6:2];
    assign cpu_byte = wb_req.adr[1:0];

    // Ack one cycle after the request is first seen
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= active & ~ack_q;
        end
    end

    always_ff @(posedge clk) begin
        if (active && !ack_q) begin
            rd_q <= mem[cpu_idx][cpu_byte];
        end
        // Write lands in the ack cycle
        if (ack_q && active && wb_req.we) begin
            mem[cpu_idx][cpu_byte] <= wb_req.dat;
        end
    end

    // Scanner port
    always_ff @(posedge clk) begin
        scan_entry <= obj_entry_t'(mem[scan_idx]);
    end

    // Dropped requests get no ack
    assign wb_rsp.ack = ack_q & active;
    assign wb_rsp.dat = rd_q;

endmodule

// File: hw/obj_scan.sv
// ======================================================================
// Line scanner. At each line start it walks the object table from the
// last entry down to entry 0, keeps the objects that cross the line
// being prepared and hands them to the draw unit one at a time.
// ======================================================================

`timescale 1ns/1ps

module obj_scan (
    input  logic                clk,
    input  logic                rst,
    input  logic                hinit,
    input  logic [7:0]          vrender,
    output logic [4:0]          scan_idx,
    input  obj_pkg::obj_entry_t scan_entry,
    output logic                draw_start,
    output obj_pkg::draw_req_t  draw_req,
    input  logic                draw_busy
);
    import obj_pkg::*;

    scan_state_e state;

    logic [4:0] idx;
    logic [8:0] ydiff;
    logic       on_line;
    logic [3:0] row;

    // Nine bits so that lines above y come out negative
    assign ydiff   = {1'b0, vrender} - {1'b0, scan_entry.y};
    assign on_line = ydiff < 9'(OBJ_H);

    // Vertical flip reads the rows bottom up
    assign row = scan_entry.attr.vflip ? 4'(OBJ_H - 1) - ydiff[3:0] : ydiff[3:0];

    assign scan_idx = idx;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state      <= SCAN_IDLE;
            idx        <= '0;
            draw_start <= 1'b0;
        end else begin
            draw_start <= 1'b0;
            if (hinit) begin
                // Restart even mid line
                idx   <= 5'(OBJ_COUNT - 1);
                state <= SCAN_READ;
            end else begin
                case (state)
                    SCAN_IDLE: begin
                        state <= SCAN_IDLE;
                    end
                    SCAN_READ: begin
                        // Entry shows up next cycle
                        state <= SCAN_TEST;
                    end
                    SCAN_TEST: begin
                        if (on_line) begin
                            state <= SCAN_WAIT;
                        end else if (idx == '0) begin
                            state <= SCAN_IDLE;
                        end else begin
                            idx   <= idx - 5'd1;
                            state <= SCAN_READ;
                        end
                    end
                    SCAN_WAIT: begin
                        // Hold the object until the draw unit is free
                        if (!draw_busy) begin
                            draw_start <= 1'b1;
                            if (idx == '0) begin
                                state <= SCAN_IDLE;
                            end else begin
                                idx   <= idx - 5'd1;
                                state <= SCAN_READ;
                            end
                        end
                    end
                    default: begin
                        state <= SCAN_IDLE;
                    end
                endcase
            end
        end
    end

    // Request payload
    always_ff @(posedge clk) begin
        if (state == SCAN_TEST && on_line) begin
            draw_req.code  <= scan_entry.code;
            draw_req.row   <= row;
            draw_req.x     <= scan_entry.x;
            draw_req.pal   <= scan_entry.attr.pal;
            draw_req.hflip <= scan_entry.attr.hflip;
        end
    end

endmodule

// File: hw/obj_draw.sv
// ======================================================================
// Draw unit. For each request it fetches the four graphics words of
// one object row from the external ROM and writes the opaque pixels
// into the line buffer, one pixel per cycle.
// ======================================================================

`timescale 1ns/1ps

module obj_draw (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         draw_start,
    input  obj_pkg::draw_req_t           draw_req,
    output logic                         busy,
    output logic                         rom_cs,
    output logic [obj_pkg::ROM_AW-1:0]   rom_addr,
    input  logic [15:0]                  rom_data,
    input  logic                         rom_ok,
    output logic                         buf_we,
    output logic [7:0]                   buf_x,
    output logic [7:0]                   buf_pxl
);
    import obj_pkg::*;

    draw_state_e state;

    draw_req_t   req;
    logic [1:0]  word;
    logic [1:0]  pix;
    logic [15:0] data_q;
    logic [3:0]  colour;
    logic [3:0]  pxl_idx;
    logic [3:0]  ofs;
    logic [8:0]  pos;

    assign busy = state != DRAW_IDLE;

    // Address is code, row, word index
    assign rom_cs   = state == DRAW_FETCH;
    assign rom_addr = {req.code, req.row, word};

    // First pixel of the word sits in the top nibble
    assign colour  = data_q[15:12];
    assign pxl_idx = {word, pix};
    assign ofs     = req.hflip ? ~pxl_idx : pxl_idx;
    assign pos     = {1'b0, req.x} + {5'd0, ofs};

    // Transparent pixels and those past the right edge are skipped
    assign buf_we  = state == DRAW_PAINT && colour != 4'd0 && !pos[8];
    assign buf_x   = pos[7:0];
    assign buf_pxl = {req.pal, colour};

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= DRAW_IDLE;
            word  <= '0;
            pix   <= '0;
        end else begin
            case (state)
                DRAW_IDLE: begin
                    if (draw_start) begin
                        word  <= '0;
                        pix   <= '0;
                        state <= DRAW_FETCH;
                    end
                end
                DRAW_FETCH: begin
                    if (rom_ok) begin
                        pix   <= '0;
                        state <= DRAW_PAINT;
                    end
                end
                DRAW_PAINT: begin
                    pix <= pix + 2'd1;
                    if (pix == 2'd3) begin
                        if (word == 2'd3) begin
                            state <= DRAW_IDLE;
                        end else begin
                            word  <= word + 2'd1;
                            state <= DRAW_FETCH;
                        end
                    end
                end
                default: begin
                    state <= DRAW_IDLE;
                end
            endcase
        end
    end

    // Request copy and pixel shifter
    always_ff @(posedge clk) begin
        if (state == DRAW_IDLE && draw_start) begin
            req <= draw_req;
        end
        if (state == DRAW_FETCH && rom_ok) begin
            data_q <= rom_data;
        end else if (state == DRAW_PAINT) begin
            data_q <= {data_q[11:0], 4'd0};
        end
    end

endmodule

// File: hw/obj_linebuf.sv
// ======================================================================
// Ping-pong line buffer. One half is painted by the draw unit while
// the other half is shown and erased as it is read. The halves swap
// at every line start.
// ======================================================================

`timescale 1ns/1ps

module obj_linebuf (
    input  logic       clk,
    input  logic       rst,
    input  logic       hinit,
    input  logic       we,
    input  logic [7:0] wr_x,
    input  logic [7:0] wr_pxl,
    input  logic       LHBL,
    input  logic [8:0] hdump,
    output logic [7:0] pxl
);
    import obj_pkg::*;

    logic [7:0] mem [2][LINE_W];

    logic       sel;
    logic       clr_run;
    logic [7:0] clr_addr;
    logic       rd_en;
    logic [7:0] rd_x;

    assign rd_x  = hdump[7:0];
    assign rd_en = LHBL && hdump < 9'(LINE_W) && !clr_run;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            sel      <= 1'b0;
            clr_run  <= 1'b1;
            clr_addr <= '0;
            pxl      <= '0;
        end else begin
            if (hinit) begin
                sel <= ~sel;
            end
            // Sweep both halves to zero after reset
            if (clr_run) begin
                clr_addr <= clr_addr + 8'd1;
                if (clr_addr == 8'(LINE_W - 1)) begin
                    clr_run <= 1'b0;
                end
            end
            pxl <= rd_en ? mem[~sel][rd_x] : 8'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (clr_run) begin
            mem[0][clr_addr] <= '0;
            mem[1][clr_addr] <= '0;
        end else begin
            if (we) begin
                mem[sel][wr_x] <= wr_pxl;
            end
            // Erase behind the readout
            if (rd_en) begin
                mem[~sel][rd_x] <= '0;
            end
        end
    end

endmodule

// File: hw/sprite_engine.sv
// ======================================================================
// Object block top level. Joins the object table, the line scanner,
// the draw unit and the line buffer. The CPU talks Wishbone, graphics
// come from an external ROM, and one 8-bit pixel index comes out.
// ======================================================================

`timescale 1ns/1ps

module sprite_engine (
    input  logic                       clk,
    input  logic                       rst,
    input  obj_pkg::wb_req_t           wb_req,
    output obj_pkg::wb_rsp_t           wb_rsp,
    input  logic                       hinit,
    input  logic                       LHBL,
    input  logic [7:0]                 vrender,
    input  logic [8:0]                 hdump,
    output logic                       rom_cs,
    output logic [obj_pkg::ROM_AW-1:0] rom_addr,
    input  logic [15:0]                rom_data,
    input  logic                       rom_ok,
    output logic [7:0]                 pxl
);
    import obj_pkg::*;

    // Table to scanner
    logic [4:0] scan_idx;
    obj_entry_t scan_entry;

    // Scanner to draw unit
    logic       draw_start;
    draw_req_t  draw_req;
    logic       draw_busy;

    // Draw unit to line buffer
    logic       buf_we;
    logic [7:0] buf_x;
    logic [7:0] buf_pxl;

    obj_ram u_ram (
        .clk        (clk),
        .rst        (rst),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .scan_idx   (scan_idx),
        .scan_entry (scan_entry)
    );

    obj_scan u_scan (
        .clk        (clk),
        .rst        (rst),
        .hinit      (hinit),
        .vrender    (vrender),
        .scan_idx   (scan_idx),
        .scan_entry (scan_entry),
        .draw_start (draw_start),
        .draw_req   (draw_req),
        .draw_busy  (draw_busy)
    );

    obj_draw u_draw (
        .clk        (clk),
        .rst        (rst),
        .draw_start (draw_start),
        .draw_req   (draw_req),
        .busy       (draw_busy),
        .rom_cs     (rom_cs),
        .rom_addr   (rom_addr),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok),
        .buf_we     (buf_we),
        .buf_x      (buf_x),
        .buf_pxl    (buf_pxl)
    );

    obj_linebuf u_linebuf (
        .clk        (clk),
        .rst        (rst),
        .hinit      (hinit),
        .we         (buf_we),
        .wr_x       (buf_x),
        .wr_pxl     (buf_pxl),
        .LHBL       (LHBL),
        .hdump      (hdump),
        .pxl        (pxl)
    );

endmodule

// File: testbench/tb_sprite_engine.sv
// ======================================================================
// Testbench for the object block. Loads object tables over Wishbone,
// renders lines against a graphics ROM model with random latency and
// compares every output pixel with a reference renderer.
// ======================================================================

`timescale 1ns/1ps

module tb_sprite_engine;
    import obj_pkg::*;

    typedef struct packed {
        logic       valid;
        logic [4:0] idx;
        obj_entry_t ent;
    } ent_wr_t;

    typedef struct packed {
        logic [7:0]    line;
        logic          rnd;
        ent_wr_t [0:3] ents;
    } test_row_t;

    localparam int      NROWS   = 14;
    localparam int      TIMEOUT = NROWS * 2 * 1536 + 5000;
    localparam ent_wr_t NO_WR   = '0;

    logic              clk;
    logic              rst;
    wb_req_t           wb_req;
    wb_rsp_t           wb_rsp;
    logic              hinit;
    logic              LHBL;
    logic [7:0]        vrender;
    logic [8:0]        hdump;
    logic              rom_cs;
    logic [ROM_AW-1:0] rom_addr;
    logic [15:0]       rom_data = '0;
    logic              rom_ok   = 1'b0;
    logic [7:0]        pxl;

    logic [2:0]        rom_wait   = '0;
    logic [2:0]        rom_lat    = 3'd1;
    logic [ROM_AW-1:0] rom_addr_q = '0;
    int                cycle_cnt  = 0;
    int                n_rows     = 0;
    string             test_name [NROWS];
    test_row_t         tests [NROWS];
    obj_entry_t        model_tbl [OBJ_COUNT];
    logic [7:0]        expected [LINE_W];

    sprite_engine DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Nibble of pixel i in one object row of the graphics ROM
    function automatic logic [3:0] rom_nibble(input logic [7:0] code, input logic [3:0] row,
                                              input logic [3:0] pix);
        return 4'(int'(code) + 3 * int'(row) + int'(pix));
    endfunction

    function automatic logic [15:0] rom_word(input logic [ROM_AW-1:0] addr);
        logic [15:0] w;
        for (int p = 0; p < 4; p++) begin
            w[15 - 4 * p -: 4] = rom_nibble(addr[13:6], addr[5:2], {addr[1:0], 2'(p)});
        end
        return w;
    endfunction

    // ROM answers after 1 to 4 cycles and holds rom_ok for one cycle
    always @(posedge clk) begin
        rom_ok <= 1'b0;
        if (rom_wait != 3'd0 && !rom_cs) begin
            stop_with_failure("ROM select dropped before the ROM answered");
        end
        if (rom_cs && !rom_ok) begin
            if (rom_wait != 3'd0 && rom_addr != rom_addr_q) begin
                stop_with_failure("ROM address changed while waiting for the ROM");
            end
            rom_addr_q <= rom_addr;
            if (rom_wait + 3'd1 >= rom_lat) begin
                rom_ok   <= 1'b1;
                rom_data <= rom_word(rom_addr);
                rom_wait <= '0;
                rom_lat  <= 3'($urandom % 4 + 1);
            end else begin
                rom_wait <= rom_wait + 3'd1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT) begin
            stop_with_failure("Timeout: the run went past its cycle limit without finishing");
        end
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            stop_with_failure($sformatf("[ERROR] %s expected %02h actual %02h", name, exp, act));
        end
    endtask

    task automatic check_pixel(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            stop_with_failure($sformatf("[ERROR] %s expected %02h actual %02h", name, exp, act));
        end
    endtask

    // One Wishbone classic access with the ack due one cycle after the request
    task automatic wb_cycle(input logic we, input logic [TBL_AW-1:0] adr,
                            input logic [7:0] wdat, output logic [7:0] rdat);
        int waits;
        waits = 0;
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        @(negedge clk);
        while (!wb_rsp.ack) begin
            waits++;
            @(negedge clk);
        end
        if (waits != 1) begin
            stop_with_failure("Wishbone ack did not come one cycle after the request");
        end
        rdat = wb_rsp.dat;
        @(posedge clk);
        wb_req <= '0;
    endtask

    task automatic write_entry(input logic [4:0] idx, input obj_entry_t e);
        logic [7:0] rd;
        for (int b = 0; b < 4; b++) begin
            wb_cycle(1'b1, {idx, 2'(b)}, e[8 * b +: 8], rd);
        end
        model_tbl[idx] = e;
    endtask

    task automatic verify_entry(input logic [4:0] idx, input string name);
        logic [7:0] rd;
        for (int b = 0; b < 4; b++) begin
            wb_cycle(1'b0, {idx, 2'(b)}, 8'h00, rd);
            check_byte($sformatf("%s entry %0d byte %0d", name, idx, b),
                       model_tbl[idx][8 * b +: 8], rd);
        end
    endtask

    // Paint from entry 31 down so that entry 0 ends on top
    task automatic render_expected(input logic [7:0] line);
        int         r;
        int         pos;
        logic [3:0] c;
        obj_entry_t e;
        for (int p = 0; p < LINE_W; p++) begin
            expected[p] = '0;
        end
        for (int k = OBJ_COUNT - 1; k >= 0; k--) begin
            e = model_tbl[k];
            r = int'(line) - int'(e.y);
            if (r >= 0 && r < OBJ_H) begin
                if (e.attr.vflip) begin
                    r = OBJ_H - 1 - r;
                end
                for (int i = 0; i < OBJ_H; i++) begin
                    c   = rom_nibble(e.code, 4'(r), 4'(i));
                    pos = e.attr.hflip ? int'(e.x) + OBJ_H - 1 - i : int'(e.x) + i;
                    if (c != 4'd0 && pos < LINE_W) begin
                        expected[pos] = {e.attr.pal, c};
                    end
                end
            end
        end
    endtask

    task automatic pulse_hinit(input logic [7:0] line);
        @(posedge clk);
        hinit   <= 1'b1;
        vrender <= line;
        @(posedge clk);
        hinit <= 1'b0;
    endtask

    // Pixel for hdump x shows up one cycle after x is applied
    task automatic sweep_line(input string name);
        for (int x = 0; x <= LINE_W; x++) begin
            @(posedge clk);
            if (x < LINE_W) begin
                hdump <= 9'(x);
                LHBL  <= 1'b1;
            end else begin
                LHBL <= 1'b0;
            end
            @(negedge clk);
            if (x > 0) begin
                check_pixel($sformatf("%s pixel %0d", name, x - 1), expected[x - 1], pxl);
            end
        end
    endtask

    task automatic run_test(input int t);
        logic [7:0] line;
        obj_entry_t e;
        line = tests[t].line;
        for (int k = 0; k < OBJ_COUNT; k++) begin
            write_entry(5'(k), '0);
        end
        if (tests[t].rnd) begin
            line = 8'(16 + $urandom % 230);
            for (int k = 0; k < OBJ_COUNT; k++) begin
                e   = obj_entry_t'($urandom);
                e.y = line - 8'($urandom % 24);
                write_entry(5'(k), e);
            end
        end else begin
            for (int j = 0; j < 4; j++) begin
                if (tests[t].ents[j].valid) begin
                    write_entry(tests[t].ents[j].idx, tests[t].ents[j].ent);
                end
            end
        end
        for (int k = 0; k < OBJ_COUNT; k++) begin
            verify_entry(5'(k), test_name[t]);
        end
        render_expected(line);
        pulse_hinit(line);
        repeat (1536) @(posedge clk);
        pulse_hinit(line);
        sweep_line(test_name[t]);
    endtask

    function automatic ent_wr_t make_write(input int idx, input int y, input int code,
                                           input int attr, input int x);
        return {1'b1, 5'(idx), 8'(x), 8'(attr), 8'(code), 8'(y)};
    endfunction

    task automatic add_row(input string name, input int line, input logic rnd,
                           input ent_wr_t e0, input ent_wr_t e1,
                           input ent_wr_t e2, input ent_wr_t e3);
        test_name[n_rows] = name;
        tests[n_rows]     = {8'(line), rnd, e0, e1, e2, e3};
        n_rows++;
    endtask

    task automatic load_tests();
        ent_wr_t one;
        one = make_write(5, 40, 'h12, 'h03, 100);
        add_row("single_mid", 47, 1'b0, one, NO_WR, NO_WR, NO_WR);
        add_row("single_top", 40, 1'b0, one, NO_WR, NO_WR, NO_WR);
        add_row("single_bottom", 55, 1'b0, one, NO_WR, NO_WR, NO_WR);
        add_row("above_zone", 39, 1'b0, one, NO_WR, NO_WR, NO_WR);
        add_row("below_zone", 56, 1'b0, one, NO_WR, NO_WR, NO_WR);
        add_row("hflip", 23, 1'b0, make_write(7, 20, 'h35, 'h45, 30), NO_WR, NO_WR, NO_WR);
        add_row("vflip", 23, 1'b0, make_write(7, 20, 'h35, 'h86, 30), NO_WR, NO_WR, NO_WR);
        add_row("hvflip", 23, 1'b0, make_write(7, 20, 'h35, 'hc7, 30), NO_WR, NO_WR, NO_WR);
        // Right edge clipping of a plain and a mirrored object
        add_row("clip_right", 23, 1'b0, make_write(12, 20, 'h40, 'h09, 245),
                make_write(13, 18, 'h41, 'h4a, 250), NO_WR, NO_WR);
        add_row("overlap", 70, 1'b0, make_write(2, 64, 'h01, 'h01, 60),
                make_write(9, 66, 'h08, 'h02, 66), make_write(20, 60, 'h11, 'h0c, 70),
                make_write(0, 69, 'h22, 'h8d, 72));
        add_row("empty_after", 120, 1'b0, NO_WR, NO_WR, NO_WR, NO_WR);
        add_row("random_a", 0, 1'b1, NO_WR, NO_WR, NO_WR, NO_WR);
        add_row("random_b", 0, 1'b1, NO_WR, NO_WR, NO_WR, NO_WR);
        add_row("random_c", 0, 1'b1, NO_WR, NO_WR, NO_WR, NO_WR);
    endtask

    initial begin
        void'($urandom(32'h68b7));
        rst     = 1'b1;
        wb_req  = '0;
        hinit   = 1'b0;
        LHBL    = 1'b0;
        vrender = '0;
        hdump   = '0;
        load_tests();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int t = 0; t < n_rows; t++) begin
            run_test(t);
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: sprite_engine.f
hw/obj_pkg.sv
hw/obj_ram.sv
hw/obj_scan.sv
hw/obj_draw.sv
hw/obj_linebuf.sv
hw/sprite_engine.sv
testbench/tb_sprite_engine.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the object block testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --top-module tb_sprite_engine \
    -f sprite_engine.f --Mdir obj_dir -o tb_sprite_engine

# A stop on the first error gives a non-zero exit status
status=0
./obj_dir/tb_sprite_engine > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q "Simulation FAILED" "$LOG" || [ "$status" -ne 0 ]; then
    echo "Run failed, see $LOG"
    exit 1
fi
echo "Run finished cleanly"
